/* include/render_params.svh */
// ==================================================
// Geometry, credit and field width constants for
// the scanline renderer
// ==================================================
`ifndef RENDER_PARAMS_SVH
`define RENDER_PARAMS_SVH

// Line and world geometry, the world wraps in both axes
`define LINE_WIDTH        64
`define LINE_X_W          6
`define WORLD_SIZE        64
`define TILE_SIZE         4
`define MAP_TILES         16

// Sprites
`define NUM_SPRITES       4
`define SPRITE_MAX        8

// Credits per source, also the compositor FIFO depth
`define PIX_CREDITS       2
`define CREDIT_W          2

`define COLOR_W           8
`define TRANSPARENT_INDEX 0

// Memory interfaces
`define MAP_ADDR_W        8
`define MAP_DATA_W        8
`define TILE_INDEX_W      6
`define TILE_PAT_ADDR_W   10
`define SPR_ATTR_ADDR_W   2
`define SPR_ATTR_W        32
`define SPR_PAT_ADDR_W    12

`endif

/* design/render_pkg.sv */
// ==================================================
// Shared types for the scanline renderer
// ==================================================
`default_nettype none
`include "render_params.svh"

package render_pkg;

  // Colour index and pixel coordinate within a line
  typedef logic [`COLOR_W-1:0]  color_t;
  typedef logic [`LINE_X_W-1:0] line_x_t;

  // Offsets inside a tile and inside a sprite
  typedef logic [$clog2(`TILE_SIZE)-1:0]  tile_off_t;
  typedef logic [$clog2(`SPRITE_MAX)-1:0] spr_off_t;

  // Attribute word as held in sprite attribute memory
  typedef struct packed {
    logic [1:0] rsvd_hi;
    logic [5:0] pat_base;
    logic [2:0] rsvd_lo;
    logic       flip_y;
    logic       flip_x;
    logic       enable;
    spr_off_t   height_m1;
    spr_off_t   width_m1;
    line_x_t    y;
    line_x_t    x;
  } sprite_attr_t;

  typedef enum logic [1:0] {
    TILE_IDLE,
    TILE_FETCH,
    TILE_DONE
  } tile_state_e;

  typedef enum logic [2:0] {
    SPR_IDLE,
    SPR_READ_ATTR,
    SPR_CHECK,
    SPR_DRAW,
    SPR_DONE
  } sprite_state_e;

endpackage

`default_nettype wire

/* design/tile_renderer.sv */
// ==================================================
// Tile layer renderer, fetches map entries and tile
// patterns and streams opaque pixels under credits
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "render_params.svh"

module tile_renderer import render_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     line_start,
  input  wire line_x_t                  line_y,
  input  wire line_x_t                  scroll_x,
  input  wire line_x_t                  scroll_y,
  input  wire logic [`TILE_INDEX_W-1:0] nop_index,
  input  wire logic [`MAP_DATA_W-1:0]   map_data,
  input  wire color_t                   tile_pat_data,
  input  wire logic                     tile_credit,
  output logic [`MAP_ADDR_W-1:0]        map_addr,
  output logic [`TILE_PAT_ADDR_W-1:0]   tile_pat_addr,
  output logic                          tile_pix_valid,
  output line_x_t                       tile_pix_x,
  output color_t                        tile_pix_color,
  output logic                          tile_done
);

  localparam int CW = `CREDIT_W;
  localparam int TW = $clog2(`TILE_SIZE);

  tile_state_e state;
  line_x_t x, world_x, world_y, scroll_x_r;
  logic [`TILE_INDEX_W-1:0] nop_r, tile_index;
  logic [CW-1:0] credits, in_flight;
  logic issue, last_x, flip_x, flip_y;

  // Stage 1 waits for the map entry, stage 2 for the pattern colour
  logic s1_valid, s2_valid;
  line_x_t s1_x, s2_x;
  tile_off_t s1_col, col, row;

  assign in_flight = CW'(s1_valid) + CW'(s2_valid);
  assign issue = (state == TILE_FETCH) && (credits > in_flight);
  assign last_x = (x == line_x_t'(`LINE_WIDTH - 1));
  assign world_x = x + scroll_x_r;

  // Tile row first, then tile column
  assign map_addr = {world_y[`LINE_X_W-1:TW], world_x[`LINE_X_W-1:TW]};

  assign tile_index = map_data[`TILE_INDEX_W-1:0];
  assign flip_x = map_data[`TILE_INDEX_W];
  assign flip_y = map_data[`TILE_INDEX_W+1];
  assign col = flip_x ? ~s1_col : s1_col;
  assign row = flip_y ? ~world_y[TW-1:0] : world_y[TW-1:0];
  assign tile_pat_addr = {tile_index, row, col};

  assign tile_pix_valid = s2_valid && (tile_pat_data != color_t'(`TRANSPARENT_INDEX));
  assign tile_pix_x = s2_x;
  assign tile_pix_color = tile_pat_data;
  assign tile_done = (state == TILE_DONE) && !s1_valid && !s2_valid;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= TILE_IDLE;
      x <= '0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= issue;
      // No-op tiles never reach the pattern fetch
      s2_valid <= s1_valid && (tile_index != nop_r);
      if (line_start) begin
        state <= TILE_FETCH;
        x <= '0;
      end else if (issue) begin
        x <= x + line_x_t'(1);
        if (last_x) begin
          state <= TILE_DONE;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (line_start) begin
      scroll_x_r <= scroll_x;
      world_y <= line_y + scroll_y;
      nop_r <= nop_index;
    end
    s1_x <= x;
    s1_col <= world_x[TW-1:0];
    s2_x <= s1_x;
  end

  // One credit per sent pixel, one back per compositor pop
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      credits <= CW'(`PIX_CREDITS);
    end else if (tile_pix_valid && !tile_credit) begin
      credits <= credits - CW'(1);
    end else if (tile_credit && !tile_pix_valid) begin
      credits <= credits + CW'(1);
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    (credits <= CW'(`PIX_CREDITS)) && !(tile_pix_valid && credits == '0))
    else $error("tile credit counter out of range");

endmodule

`default_nettype wire

/* design/sprite_renderer.sv */
// ==================================================
// Sprite renderer, scans four sprite attributes and
// streams pixels of the sprites on the current line
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "render_params.svh"

module sprite_renderer import render_pkg::*; (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic                        line_start,
  input  wire line_x_t                     line_y,
  input  wire logic [`SPR_ATTR_W-1:0]      spr_attr_data,
  input  wire color_t                      spr_pat_data,
  input  wire logic                        sprite_credit,
  output logic [`SPR_ATTR_ADDR_W-1:0]      spr_attr_addr,
  output logic [`SPR_PAT_ADDR_W-1:0]       spr_pat_addr,
  output logic                             sprite_pix_valid,
  output line_x_t                          sprite_pix_x,
  output color_t                           sprite_pix_color,
  output logic                             sprite_done
);

  localparam int CW = `CREDIT_W;
  localparam int AW = `SPR_ATTR_ADDR_W;

  sprite_state_e state;
  logic [AW-1:0] spr_idx;
  line_x_t line_y_r, row_off;
  sprite_attr_t attr, attr_r;
  spr_off_t px, src_row, src_col;
  logic [CW-1:0] credits;
  logic hit, issue, last_px, last_sprite;

  // Pattern fetch in flight
  logic p1_valid;
  line_x_t p1_x;

  assign attr = sprite_attr_t'(spr_attr_data);
  assign row_off = line_y_r - attr.y;
  assign hit = attr.enable && (row_off <= line_x_t'(attr.height_m1));
  assign last_sprite = (spr_idx == AW'(`NUM_SPRITES - 1));

  assign issue = (state == SPR_DRAW) && (credits > CW'(p1_valid));
  assign last_px = (px == attr_r.width_m1);
  assign src_col = attr_r.flip_x ? attr_r.width_m1 - px : px;

  assign spr_attr_addr = spr_idx;
  // Base, then row, then column
  assign spr_pat_addr = {attr_r.pat_base, src_row, src_col};

  assign sprite_pix_valid = p1_valid && (spr_pat_data != color_t'(`TRANSPARENT_INDEX));
  assign sprite_pix_x = p1_x;
  assign sprite_pix_color = spr_pat_data;
  assign sprite_done = (state == SPR_DONE) && !p1_valid;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= SPR_IDLE;
      spr_idx <= '0;
      px <= '0;
      p1_valid <= 1'b0;
    end else begin
      p1_valid <= issue;
      if (line_start) begin
        state <= SPR_READ_ATTR;
        spr_idx <= '0;
      end else begin
        case (state)
          SPR_READ_ATTR: begin
            state <= SPR_CHECK;
          end
          SPR_CHECK: begin
            px <= '0;
            if (hit) begin
              state <= SPR_DRAW;
            end else begin
              state <= last_sprite ? SPR_DONE : SPR_READ_ATTR;
              spr_idx <= spr_idx + AW'(1);
            end
          end
          SPR_DRAW: begin
            if (issue) begin
              px <= px + spr_off_t'(1);
              if (last_px) begin
                state <= last_sprite ? SPR_DONE : SPR_READ_ATTR;
                spr_idx <= spr_idx + AW'(1);
              end
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (line_start) begin
      line_y_r <= line_y;
    end
    // Latch the sprite and its source row while checking it
    if (state == SPR_CHECK) begin
      attr_r <= attr;
      src_row <= attr.flip_y ? attr.height_m1 - spr_off_t'(row_off) : spr_off_t'(row_off);
    end
    p1_x <= attr_r.x + line_x_t'(px);
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      credits <= CW'(`PIX_CREDITS);
    end else if (sprite_pix_valid && !sprite_credit) begin
      credits <= credits - CW'(1);
    end else if (sprite_credit && !sprite_pix_valid) begin
      credits <= credits + CW'(1);
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    (credits <= CW'(`PIX_CREDITS)) && !(sprite_pix_valid && credits == '0))
    else $error("sprite credit counter out of range");

endmodule

`default_nettype wire

/* design/line_compositor.sv */
// ==================================================
// Line compositor, merges tile and sprite pixels into
// a double-buffered line buffer and scans it out
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "render_params.svh"

module line_compositor import render_pkg::*; (
  input  wire logic    clk,
  input  wire logic    reset,
  input  wire logic    line_start,
  input  wire logic    tile_pix_valid,
  input  wire line_x_t tile_pix_x,
  input  wire color_t  tile_pix_color,
  input  wire logic    sprite_pix_valid,
  input  wire line_x_t sprite_pix_x,
  input  wire color_t  sprite_pix_color,
  input  wire logic    tile_done,
  input  wire logic    sprite_done,
  input  wire logic    scan_en,
  input  wire line_x_t scan_x,
  output logic         tile_credit,
  output logic         sprite_credit,
  output logic         line_done,
  output logic         scan_valid,
  output color_t       scan_color
);

  localparam int PTR_W = $clog2(`PIX_CREDITS);
  localparam int CNT_W = $clog2(`PIX_CREDITS + 1);
  localparam int BUF_DEPTH = 2 * `LINE_WIDTH;

  // Source 0 is the tile stream, source 1 the sprite stream
  logic [1:0] push, pop, not_empty;
  line_x_t [1:0] in_x, head_x;
  color_t [1:0] in_color, head_color;
  logic sel, last_sel;

  // Both line buffers in one array, the top address bit picks the bank
  color_t buf_color [BUF_DEPTH];
  logic buf_flag [BUF_DEPTH];
  logic back;
  logic [`LINE_X_W:0] wr_addr, rd_addr;

  assign push = {sprite_pix_valid, tile_pix_valid};
  assign in_x = {sprite_pix_x, tile_pix_x};
  assign in_color = {sprite_pix_color, tile_pix_color};

  for (genvar s = 0; s < 2; s++) begin : g_fifo
    line_x_t x_mem [`PIX_CREDITS];
    color_t c_mem [`PIX_CREDITS];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
      end else begin
        if (push[s]) begin
          wr_ptr <= wr_ptr + PTR_W'(1);
        end
        if (pop[s]) begin
          rd_ptr <= rd_ptr + PTR_W'(1);
        end
        count <= count + CNT_W'(push[s]) - CNT_W'(pop[s]);
      end
    end

    always_ff @(posedge clk) begin
      if (push[s]) begin
        x_mem[wr_ptr] <= in_x[s];
        c_mem[wr_ptr] <= in_color[s];
      end
    end

    assign not_empty[s] = (count != '0);
    assign head_x[s] = x_mem[rd_ptr];
    assign head_color[s] = c_mem[rd_ptr];

    // Renderer credits must keep every push within the FIFO depth
    assert property (@(posedge clk) disable iff (reset)
      push[s] |-> count < CNT_W'(`PIX_CREDITS))
      else $error("pixel FIFO %0d overflow", s);
  end

  // Alternate sources when both hold data
  assign sel = (not_empty == 2'b11) ? ~last_sel : not_empty[1];
  assign pop = (not_empty == 2'b00) ? 2'b00 : (sel ? 2'b10 : 2'b01);
  assign tile_credit = pop[0];
  assign sprite_credit = pop[1];
  assign line_done = tile_done && sprite_done && (not_empty == 2'b00);

  assign wr_addr = {back, head_x[sel]};
  assign rd_addr = {~back, scan_x};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < BUF_DEPTH; i++) begin
        buf_color[i] <= '0;
        buf_flag[i] <= 1'b0;
      end
      back <= 1'b0;
      last_sel <= 1'b0;
      scan_valid <= 1'b0;
    end else begin
      if (line_start) begin
        back <= ~back;
      end
      // Sprites always land, tiles only where no sprite has
      if (pop != 2'b00) begin
        last_sel <= sel;
        if (sel || !buf_flag[wr_addr]) begin
          buf_color[wr_addr] <= head_color[sel];
        end
        if (sel) begin
          buf_flag[wr_addr] <= 1'b1;
        end
      end
      // Clear on read so the bank is blank when it becomes the back buffer
      scan_valid <= scan_en;
      if (scan_en) begin
        buf_color[rd_addr] <= '0;
        buf_flag[rd_addr] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (scan_en) begin
      scan_color <= buf_color[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* design/line_renderer.sv */
// ==================================================
// Scanline renderer top, tile and sprite renderers
// feeding the line compositor
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "render_params.svh"

module line_renderer import render_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     line_start,
  input  wire line_x_t                  line_y,
  input  wire line_x_t                  scroll_x,
  input  wire line_x_t                  scroll_y,
  input  wire logic [`TILE_INDEX_W-1:0] nop_index,
  output wire logic [`MAP_ADDR_W-1:0]   map_addr,
  input  wire logic [`MAP_DATA_W-1:0]   map_data,
  output wire logic [`TILE_PAT_ADDR_W-1:0] tile_pat_addr,
  input  wire color_t                   tile_pat_data,
  output wire logic [`SPR_ATTR_ADDR_W-1:0] spr_attr_addr,
  input  wire logic [`SPR_ATTR_W-1:0]   spr_attr_data,
  output wire logic [`SPR_PAT_ADDR_W-1:0] spr_pat_addr,
  input  wire color_t                   spr_pat_data,
  input  wire logic                     scan_en,
  input  wire line_x_t                  scan_x,
  output wire logic                     scan_valid,
  output wire color_t                   scan_color,
  output wire logic                     line_done
);

  // Pixel channels and credit returns
  wire logic    tile_pix_valid, sprite_pix_valid;
  wire line_x_t tile_pix_x, sprite_pix_x;
  wire color_t  tile_pix_color, sprite_pix_color;
  wire logic    tile_credit, sprite_credit;
  wire logic    tile_done, sprite_done;

  tile_renderer u_tile_renderer (
    .clk            (clk),
    .reset          (reset),
    .line_start     (line_start),
    .line_y         (line_y),
    .scroll_x       (scroll_x),
    .scroll_y       (scroll_y),
    .nop_index      (nop_index),
    .map_data       (map_data),
    .tile_pat_data  (tile_pat_data),
    .tile_credit    (tile_credit),
    .map_addr       (map_addr),
    .tile_pat_addr  (tile_pat_addr),
    .tile_pix_valid (tile_pix_valid),
    .tile_pix_x     (tile_pix_x),
    .tile_pix_color (tile_pix_color),
    .tile_done      (tile_done)
  );

  sprite_renderer u_sprite_renderer (
    .clk              (clk),
    .reset            (reset),
    .line_start       (line_start),
    .line_y           (line_y),
    .spr_attr_data    (spr_attr_data),
    .spr_pat_data     (spr_pat_data),
    .sprite_credit    (sprite_credit),
    .spr_attr_addr    (spr_attr_addr),
    .spr_pat_addr     (spr_pat_addr),
    .sprite_pix_valid (sprite_pix_valid),
    .sprite_pix_x     (sprite_pix_x),
    .sprite_pix_color (sprite_pix_color),
    .sprite_done      (sprite_done)
  );

  line_compositor u_line_compositor (
    .clk              (clk),
    .reset            (reset),
    .line_start       (line_start),
    .tile_pix_valid   (tile_pix_valid),
    .tile_pix_x       (tile_pix_x),
    .tile_pix_color   (tile_pix_color),
    .sprite_pix_valid (sprite_pix_valid),
    .sprite_pix_x     (sprite_pix_x),
    .sprite_pix_color (sprite_pix_color),
    .tile_done        (tile_done),
    .sprite_done      (sprite_done),
    .scan_en          (scan_en),
    .scan_x           (scan_x),
    .tile_credit      (tile_credit),
    .sprite_credit    (sprite_credit),
    .line_done        (line_done),
    .scan_valid       (scan_valid),
    .scan_color       (scan_color)
  );

endmodule

`default_nettype wire

/* verification/tb_checks.svh */
// ==================================================
// Testbench test image loader, error counters and
// the value compare task
// ==================================================
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Regions of the unified test image
localparam int MAP_BASE      = 'h0000;
localparam int TILE_PAT_BASE = 'h0100;
localparam int SPR_ATTR_BASE = 'h0500;
localparam int SPR_PAT_BASE  = 'h1000;
localparam int CMD_BASE      = 'h2000;
localparam int REC_LEN       = `LINE_WIDTH + 1;
localparam int IMAGE_DEPTH   = 'h4000;

logic [31:0] image [IMAGE_DEPTH];
int error_count = 0;
int check_count = 0;
int num_lines = 0;

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("ERR %s expected 0x%02h actual 0x%02h at %0t", name, expected, actual, $time);
  end
endtask

// Records follow each other until one lacks the valid bit
task automatic load_tests();
  for (int i = 0; i < IMAGE_DEPTH; i++) begin
    image[i] = '0;
  end
  $readmemh("verification/render_tests.dat", image);
  num_lines = 0;
  while ((CMD_BASE + (num_lines + 1) * REC_LEN <= IMAGE_DEPTH) &&
         image[CMD_BASE + num_lines * REC_LEN][31]) begin
    num_lines++;
  end
endtask

function automatic logic [31:0] cmd_word(input int n);
  return image[CMD_BASE + n * REC_LEN];
endfunction

function automatic color_t expected_color(input int n, input int x);
  return image[CMD_BASE + n * REC_LEN + 1 + x][`COLOR_W-1:0];
endfunction

`endif

/* verification/tb_line_renderer.sv */
// ==================================================
// Testbench for the scanline renderer that renders
// each line command and checks the scanned-out pixels
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "render_params.svh"

module tb_line_renderer import render_pkg::*; ();

  logic clk = 1'b0;
  logic reset;
  logic line_start;
  line_x_t line_y, scroll_x, scroll_y;
  logic [`TILE_INDEX_W-1:0] nop_index;
  logic [`MAP_DATA_W-1:0] map_data = '0;
  color_t tile_pat_data = '0;
  logic [`SPR_ATTR_W-1:0] spr_attr_data = '0;
  color_t spr_pat_data = '0;
  logic scan_en;
  line_x_t scan_x;
  logic tests_loaded = 1'b0;
  integer seed;

  wire logic [`MAP_ADDR_W-1:0] map_addr;
  wire logic [`TILE_PAT_ADDR_W-1:0] tile_pat_addr;
  wire logic [`SPR_ATTR_ADDR_W-1:0] spr_attr_addr;
  wire logic [`SPR_PAT_ADDR_W-1:0] spr_pat_addr;
  wire logic scan_valid;
  wire color_t scan_color;
  wire logic line_done;

  `include "tb_checks.svh"

  always #4 clk = ~clk;

  line_renderer DUT (
    .clk           (clk),
    .reset         (reset),
    .line_start    (line_start),
    .line_y        (line_y),
    .scroll_x      (scroll_x),
    .scroll_y      (scroll_y),
    .nop_index     (nop_index),
    .map_addr      (map_addr),
    .map_data      (map_data),
    .tile_pat_addr (tile_pat_addr),
    .tile_pat_data (tile_pat_data),
    .spr_attr_addr (spr_attr_addr),
    .spr_attr_data (spr_attr_data),
    .spr_pat_addr  (spr_pat_addr),
    .spr_pat_data  (spr_pat_data),
    .scan_en       (scan_en),
    .scan_x        (scan_x),
    .scan_valid    (scan_valid),
    .scan_color    (scan_color),
    .line_done     (line_done)
  );

  // Synchronous memories with one cycle of latency
  always @(posedge clk) begin
    map_data <= image[MAP_BASE + int'(map_addr)][`MAP_DATA_W-1:0];
    tile_pat_data <= image[TILE_PAT_BASE + int'(tile_pat_addr)][`COLOR_W-1:0];
    spr_attr_data <= image[SPR_ATTR_BASE + int'(spr_attr_addr)];
    spr_pat_data <= image[SPR_PAT_BASE + int'(spr_pat_addr)][`COLOR_W-1:0];
  end

  task automatic start_line(input int n);
    logic [31:0] cmd;
    cmd = cmd_word(n);
    @(posedge clk);
    line_start <= 1'b1;
    line_y <= cmd[5:0];
    scroll_x <= cmd[13:8];
    scroll_y <= cmd[21:16];
    nop_index <= cmd[29:24];
    @(posedge clk);
    line_start <= 1'b0;
  endtask

  task automatic wait_line_done();
    do begin
      @(posedge clk);
    end while (!line_done);
  endtask

  // Scan the front buffer with random gaps in scan_en
  task automatic scan_line(input int n);
    int x;
    int checked;
    int pending [$];
    logic [1:0] en_hist;
    x = 0;
    checked = 0;
    en_hist = 2'b00;
    while (checked < `LINE_WIDTH) begin
      @(posedge clk);
      // Read data follows the scan_en cycle by exactly one cycle
      check_value("scan_valid", 32'(en_hist[1]), 32'(scan_valid));
      if (en_hist[1]) begin
        check_value($sformatf("scan_color[%0d]", pending[0]),
                    32'(expected_color(n, pending[0])), 32'(scan_color));
        void'(pending.pop_front());
        checked++;
      end
      if (x < `LINE_WIDTH && ($random(seed) & 3) != 0) begin
        scan_en <= 1'b1;
        scan_x <= line_x_t'(x);
        pending.push_back(x);
        x++;
        en_hist = {en_hist[0], 1'b1};
      end else begin
        scan_en <= 1'b0;
        en_hist = {en_hist[0], 1'b0};
      end
    end
    scan_en <= 1'b0;
  endtask

  initial begin
    seed = 32'hba60;
    reset = 1'b1;
    line_start = 1'b0;
    line_y = '0;
    scroll_x = '0;
    scroll_y = '0;
    nop_index = '0;
    scan_en = 1'b0;
    scan_x = '0;
    load_tests();
    tests_loaded = 1'b1;
    if (num_lines == 0) begin
      $display("No line commands were found in the test file");
      error_count++;
    end
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    if (num_lines > 0) begin
      start_line(0);
      // Each line is scanned while the following one renders
      for (int n = 1; n <= num_lines; n++) begin
        wait_line_done();
        start_line(n < num_lines ? n : 0);
        scan_line(n - 1);
      end
    end
    $display("Ran %0d checks with %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    int limit_cycles;
    wait (tests_loaded);
    limit_cycles = 10 + 400 * (num_lines + 1);
    #(limit_cycles * 8);
    $display("Watchdog timeout, the line commands did not complete in time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/render_tests.dat */
// Test image, one hex word per entry. Map at 000, tile patterns at 100, sprite attributes
// at 500, sprite patterns at 1000, line records at 2000 (command word then 64 colours)
@000 01 02 41 81 03
@110 10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F
@120 20 00 22 23 24 00 26 27 28 00 2A 2B 2C 00 2E 2F
@130 33 33 33 33 33 33 33 33 33 33 33 33 33 33 33 33
@500 0104B508 020CB50A 0100F500 0315BA3E
@1040 51 52 00 54 00 00 00 00 55 56 57 58 00 00 00 00
@1080 61 62 63 64 00 00 00 00 65 00 67 68 00 00 00 00
@10C0 70 71 72 73 00 00 00 00 74 75 76 77 00 00 00 00
@10D0 78 79 7A 7B 00 00 00 00 7C 7D 7E 7F 00 00 00 00
// Command word: bit 31 valid, nop_index 29:24, scroll_y 21:16, scroll_x 13:8, line_y 5:0
@2000 BF000000
10 11 12 13 20 00 22 23 13 12 11 10 1C 1D 1E 1F 33 33 33 33 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
83003E01
00 00 14 15 16 17 24 00 26 27 17 16 15 14 18 19 1A 1B 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
BF03053E
00 26 27 17 16 15 14 18 19 1A 1B 33 33 33 33 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 14 15 16 17 24
BF2C0014
10 11 12 13 20 00 22 23 51 52 64 63 62 61 1E 1F 33 33 33 33 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
BF2B0015
10 11 12 13 20 00 22 23 55 56 68 67 1C 65 1E 1F 33 33 33 33 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
83170029
7A 7B 12 13 20 00 22 23 13 12 11 10 1C 1D 1E 1F 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 78 79

/* project.f */
+incdir+include
+incdir+verification
design/render_pkg.sv
design/tile_renderer.sv
design/sprite_renderer.sv
design/line_compositor.sv
design/line_renderer.sv
verification/tb_line_renderer.sv

/* Makefile */
# Verilator build for the scanline renderer

VERILATOR ?= verilator
TOP       ?= tb_line_renderer
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(shell sed -n '/^[^+]/p' $(FILELIST)) verification/tb_checks.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
